//--- key_bank.sv
module key_bank (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  load,
    input  sort_cfg_pkg::addr_t   load_addr,
    input  sort_cfg_pkg::key_t    load_data,
    input  logic                  busy,
    input  logic                  wb_push,
    input  sort_cfg_pkg::addr_t   wb_addr,
    input  sort_cfg_pkg::key_t    wb_data,
    input  sort_cfg_pkg::addr_t   read_addr,
    output sort_cfg_pkg::key_t    keys [sort_cfg_pkg::NUM_KEYS],
    output sort_cfg_pkg::key_t    read_data
);
    import sort_cfg_pkg::*;

    // Load port owns the bank while idle, write-back while sorting
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_KEYS; i++) begin
                keys[i] <= '0;
            end
        end else if (busy) begin
            if (wb_push) begin
                keys[wb_addr] <= wb_data;
            end
        end else if (load) begin
            keys[load_addr] <= load_data;
        end
    end

    // Observation port
    assign read_data = keys[read_addr];

endmodule

//--- merge_sort_sva.sv
module merge_sort_sva (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  done,
    input  logic                  busy,
    input  logic                  load,
    input  sort_cfg_pkg::addr_t   load_addr,
    input  logic                  wb_push,
    input  sort_cfg_pkg::addr_t   wb_addr,
    input  sort_cfg_pkg::key_t    keys [sort_cfg_pkg::NUM_KEYS],
    input  logic [3:0]            pair_push,
    input  logic [3:0]            pair_full,
    input  logic [1:0]            m1_push,
    input  logic [1:0]            run2_full
);
    import sort_cfg_pkg::*;
    import sort_ctrl_pkg::*;

    key_t load_entry;
    logic load_while_busy;

    // Entry addressed by the load port
    assign load_entry = keys[load_addr];

    // A write-back to the same entry is allowed to change it
    assign load_while_busy = busy && load && !(wb_push && wb_addr == load_addr);

    // ------------------------------
    // Protocol rules
    // ------------------------------
    a_done_single: assert property (@(posedge clock) disable iff (!arst_n)
        done |=> !done)
        else $error("done stayed high for two cycles");

    a_pair_push_full: assert property (@(posedge clock) disable iff (!arst_n)
        !(|(pair_push & pair_full)))
        else $error("pair FIFO pushed while full");

    a_run2_push_full: assert property (@(posedge clock) disable iff (!arst_n)
        !(|(m1_push & run2_full)))
        else $error("run FIFO pushed while full");

    a_load_busy: assert property (@(posedge clock) disable iff (!arst_n)
        load_while_busy |=> keys[$past(load_addr)] == $past(load_entry))
        else $error("load changed the key bank while busy");

endmodule

bind merge_sort_top merge_sort_sva u_sva (
    .clock(clock),
    .arst_n(arst_n),
    .done(done),
    .busy(busy),
    .load(load),
    .load_addr(load_addr),
    .wb_push(wb_push),
    .wb_addr(wb_addr),
    .keys(keys),
    .pair_push(pair_push),
    .pair_full(pair_full),
    .m1_push(m1_push),
    .run2_full(run2_full)
);

//--- merge_sort_top.sv
module merge_sort_top (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  load,
    input  sort_cfg_pkg::addr_t   load_addr,
    input  sort_cfg_pkg::key_t    load_data,
    input  logic                  start,
    input  sort_cfg_pkg::addr_t   read_addr,
    output sort_cfg_pkg::key_t    read_data,
    output logic                  done
);
    import sort_cfg_pkg::*;

    key_t       keys [NUM_KEYS];
    logic       go;
    logic       busy;
    logic       wb_push;
    addr_t      wb_addr;
    key_t       wb_data;

    // Pair stage
    logic [3:0] pair_push;
    key_t       pair_data [4];
    logic [3:0] pair_pop;
    key_t       pair_head [4];
    logic [3:0] pair_full;
    logic [3:0] pair_empty;

    // Runs of four
    logic [1:0] m1_push;
    key_t       m1_data [2];
    logic [1:0] run2_pop;
    key_t       run2_head [2];
    logic [1:0] run2_full;
    logic [1:0] run2_empty;

    key_bank u_bank (
        .clock, .arst_n, .load, .load_addr, .load_data, .busy,
        .wb_push, .wb_addr, .wb_data, .read_addr, .keys, .read_data
    );

    sort_ctrl u_ctrl (
        .clock, .arst_n, .start, .wb_push, .go, .busy, .wb_addr, .done
    );

    // ------------------------------
    // Pair sorters and first FIFOs
    // ------------------------------
    for (genvar i = 0; i < 4; i++) begin : g_pair
        pair_sorter u_sorter (
            .clock, .arst_n, .go,
            .key_a(keys[2*i]), .key_b(keys[2*i+1]),
            .push(pair_push[i]), .data(pair_data[i])
        );
        run_fifo #(.DEPTH(PAIR_FIFO_DEPTH)) u_fifo (
            .clock, .arst_n,
            .push(pair_push[i]), .data_in(pair_data[i]), .pop(pair_pop[i]),
            .data_out(pair_head[i]), .full(pair_full[i]), .empty(pair_empty[i])
        );
    end

    // ------------------------------
    // First merge tier
    // ------------------------------
    for (genvar j = 0; j < 2; j++) begin : g_tier1
        run_merger #(.RUN_LEN(PAIR_FIFO_DEPTH)) u_merger (
            .clock, .arst_n,
            .head_a(pair_head[2*j]), .empty_a(pair_empty[2*j]),
            .head_b(pair_head[2*j+1]), .empty_b(pair_empty[2*j+1]),
            .out_full(run2_full[j]),
            .pop_a(pair_pop[2*j]), .pop_b(pair_pop[2*j+1]),
            .out_push(m1_push[j]), .out_data(m1_data[j])
        );
        run_fifo #(.DEPTH(RUN2_FIFO_DEPTH)) u_fifo (
            .clock, .arst_n,
            .push(m1_push[j]), .data_in(m1_data[j]), .pop(run2_pop[j]),
            .data_out(run2_head[j]), .full(run2_full[j]), .empty(run2_empty[j])
        );
    end

    // Final merge writes straight into the bank
    run_merger #(.RUN_LEN(RUN2_FIFO_DEPTH)) u_final (
        .clock, .arst_n,
        .head_a(run2_head[0]), .empty_a(run2_empty[0]),
        .head_b(run2_head[1]), .empty_b(run2_empty[1]),
        .out_full(1'b0),
        .pop_a(run2_pop[0]), .pop_b(run2_pop[1]),
        .out_push(wb_push), .out_data(wb_data)
    );

endmodule

//--- pair_sorter.sv
module pair_sorter (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 go,
    input  sort_cfg_pkg::key_t   key_a,
    input  sort_cfg_pkg::key_t   key_b,
    output logic                 push,
    output sort_cfg_pkg::key_t   data
);
    import sort_cfg_pkg::*;

    key_t big_q;
    logic second_pending;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            push           <= 1'b0;
            second_pending <= 1'b0;
        end else begin
            push           <= go | second_pending;
            second_pending <= go;
        end
    end

    // Smaller key goes out first, larger one is held for the next cycle
    always_ff @(posedge clock) begin
        if (go) begin
            data  <= (key_a <= key_b) ? key_a : key_b;
            big_q <= (key_a <= key_b) ? key_b : key_a;
        end else if (second_pending) begin
            data <= big_q;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the merge sort testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_merge_sort -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Compile failed with status $status"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1

//--- run_fifo.sv
module run_fifo #(
    parameter int DEPTH = 2
) (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 push,
    input  sort_cfg_pkg::key_t   data_in,
    input  logic                 pop,
    output sort_cfg_pkg::key_t   data_out,
    output logic                 full,
    output logic                 empty
);
    import sort_cfg_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    key_t             mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Show-ahead head
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- run_merger.sv
module run_merger #(
    parameter int RUN_LEN = 2
) (
    input  logic                 clock,
    input  logic                 arst_n,
    input  sort_cfg_pkg::key_t   head_a,
    input  logic                 empty_a,
    input  sort_cfg_pkg::key_t   head_b,
    input  logic                 empty_b,
    input  logic                 out_full,
    output logic                 pop_a,
    output logic                 pop_b,
    output logic                 out_push,
    output sort_cfg_pkg::key_t   out_data
);
    import sort_cfg_pkg::*;

    localparam int CNT_W = $clog2(RUN_LEN + 1);

    logic [CNT_W-1:0] taken_a;
    logic [CNT_W-1:0] taken_b;
    logic             done_a;
    logic             done_b;
    logic             last_pop;
    key_t             pick;

    assign done_a = (taken_a == CNT_W'(RUN_LEN));
    assign done_b = (taken_b == CNT_W'(RUN_LEN));

    // ------------------------------
    // Head selection
    // ------------------------------
    always_comb begin
        pop_a = 1'b0;
        pop_b = 1'b0;
        if (!out_full) begin
            if (!done_a && !done_b) begin
                // Ties go to side a
                if (!empty_a && !empty_b) begin
                    if (head_a <= head_b) begin
                        pop_a = 1'b1;
                    end else begin
                        pop_b = 1'b1;
                    end
                end
            end else if (!done_a) begin
                pop_a = !empty_a;
            end else if (!done_b) begin
                pop_b = !empty_b;
            end
        end
    end

    assign pick = pop_a ? head_a : head_b;

    // Final key of the merged run
    assign last_pop = (pop_a && done_b && taken_a == CNT_W'(RUN_LEN - 1)) ||
                      (pop_b && done_a && taken_b == CNT_W'(RUN_LEN - 1));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            taken_a  <= '0;
            taken_b  <= '0;
            out_push <= 1'b0;
        end else begin
            out_push <= pop_a | pop_b;
            if (last_pop) begin
                taken_a <= '0;
                taken_b <= '0;
            end else begin
                if (pop_a) taken_a <= taken_a + 1'b1;
                if (pop_b) taken_b <= taken_b + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pop_a | pop_b) begin
            out_data <= pick;
        end
    end

endmodule

//--- sim.f
sort_cfg_pkg.sv
sort_ctrl_pkg.sv
key_bank.sv
pair_sorter.sv
run_fifo.sv
run_merger.sv
sort_ctrl.sv
merge_sort_top.sv
merge_sort_sva.sv
tb_merge_sort.sv

//--- sort_cfg_pkg.sv
package sort_cfg_pkg;

    // ------------------------------
    // Key format
    // ------------------------------
    localparam int KEY_W    = 8;
    localparam int NUM_KEYS = 8;
    localparam int ADDR_W   = 3;

    typedef logic [KEY_W-1:0]  key_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // ------------------------------
    // FIFO sizing per merge tier
    // ------------------------------
    // Each depth equals the run length it holds
    localparam int PAIR_FIFO_DEPTH = 2;
    localparam int RUN2_FIFO_DEPTH = 4;

endpackage

//--- sort_ctrl.sv
module sort_ctrl (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic                  wb_push,
    output logic                  go,
    output logic                  busy,
    output sort_cfg_pkg::addr_t   wb_addr,
    output logic                  done
);
    import sort_cfg_pkg::*;
    import sort_ctrl_pkg::*;

    sort_state_t state;
    logic        last_wb;

    // Eighth write-back of the run
    assign last_wb = wb_push && (wb_addr == addr_t'(NUM_KEYS - 1));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            go      <= 1'b0;
            wb_addr <= '0;
        end else begin
            go <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state   <= ST_SORT;
                        go      <= 1'b1;
                        wb_addr <= '0;
                    end
                end
                ST_SORT: begin
                    if (wb_push) begin
                        wb_addr <= wb_addr + 1'b1;
                    end
                    if (last_wb) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ST_DONE lasts one cycle, so done is a single pulse
    assign done = (state == ST_DONE);
    assign busy = (state != ST_IDLE);

endmodule

//--- sort_ctrl_pkg.sv
package sort_ctrl_pkg;

    // Controller states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_SORT = 2'd1,
        ST_DONE = 2'd2
    } sort_state_t;

endpackage

//--- tb_merge_sort.sv
module tb_merge_sort;
    import sort_cfg_pkg::*;
    import sort_ctrl_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int CYCLE_BOUND = 200;
    localparam int NUM_TESTS   = 15;

    logic  clock;
    logic  arst_n;
    logic  load;
    addr_t load_addr;
    key_t  load_data;
    logic  start;
    addr_t read_addr;
    key_t  read_data;
    logic  done;

    key_t  loaded   [NUM_KEYS];
    key_t  expected [NUM_KEYS];
    int    seed;
    int    error_count;
    int    pass_count;
    int    fail_count;

    merge_sort_top uut (
        .clock, .arst_n, .load, .load_addr, .load_data,
        .start, .read_addr, .read_data, .done
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Watchdog sized from the per-test bound
    initial begin
        #(NUM_TESTS * CYCLE_BOUND * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", NUM_TESTS * CYCLE_BOUND);
        $display("RESULT: FAIL");
        $finish;
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_key(input string name, input key_t got, input key_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_done(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    task automatic load_all();
        for (int i = 0; i < NUM_KEYS; i++) begin
            @(posedge clock);
            load      <= 1'b1;
            load_addr <= addr_t'(i);
            load_data <= loaded[i];
        end
        @(posedge clock);
        load <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
    endtask

    // Done must come, and must drop after one cycle
    task automatic wait_done();
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < CYCLE_BOUND) begin
            @(negedge clock);
            cycles++;
            if (done) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("Error: done never arrived within %0d cycles of start", CYCLE_BOUND);
            error_count++;
        end else begin
            @(negedge clock);
            check_done("done", done, 1'b0);
        end
    endtask

    // Loads on every cycle until done, with data the bank must never take
    task automatic load_until_done();
        int    cycles;
        logic  seen;
        addr_t target;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < CYCLE_BOUND) begin
            @(posedge clock);
            target     = addr_t'(cycles);
            load      <= 1'b1;
            load_addr <= target;
            load_data <= ~expected[target];
            @(negedge clock);
            cycles++;
            seen = done;
        end
        @(posedge clock);
        load <= 1'b0;
    endtask

    // Reference order, plain insertion sort
    function automatic void sort_expected();
        key_t tmp;
        for (int i = 0; i < NUM_KEYS; i++) begin
            expected[i] = loaded[i];
        end
        for (int i = 1; i < NUM_KEYS; i++) begin
            for (int j = i; j > 0 && expected[j-1] > expected[j]; j--) begin
                tmp           = expected[j];
                expected[j]   = expected[j-1];
                expected[j-1] = tmp;
            end
        end
    endfunction

    task automatic read_back();
        for (int i = 0; i < NUM_KEYS; i++) begin
            @(posedge clock);
            read_addr <= addr_t'(i);
            @(negedge clock);
            check_key($sformatf("read_data[%0d]", i), read_data, expected[i]);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            pass_count++;
            $display("Test %s passed", name);
        end else begin
            fail_count++;
            $display("Test %s failed with %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic sort_and_check(input string name);
        int errs;
        errs = error_count;
        load_all();
        sort_expected();
        pulse_start();
        wait_done();
        read_back();
        finish_test(name, errs);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_reset_state();
        int errs;
        errs = error_count;
        @(negedge clock);
        check_done("done", done, 1'b0);
        for (int i = 0; i < NUM_KEYS; i++) begin
            expected[i] = '0;
        end
        read_back();
        finish_test("reset_state", errs);
    endtask

    task automatic test_descending();
        for (int i = 0; i < NUM_KEYS; i++) begin
            loaded[i] = key_t'(200 - 20 * i);
        end
        sort_and_check("descending");
    endtask

    task automatic test_ascending();
        for (int i = 0; i < NUM_KEYS; i++) begin
            loaded[i] = key_t'(3 + 30 * i);
        end
        sort_and_check("ascending");
    endtask

    task automatic test_random(input int n);
        for (int i = 0; i < NUM_KEYS; i++) begin
            loaded[i] = key_t'($random(seed));
        end
        // Forced duplicates on some lists
        if (n % 2 == 0) begin
            loaded[7] = loaded[0];
            loaded[4] = loaded[1];
        end
        if (n % 3 == 0) begin
            loaded[2] = loaded[5];
            loaded[6] = loaded[5];
        end
        sort_and_check($sformatf("random_%0d", n));
    endtask

    task automatic test_busy_inputs();
        int errs;
        errs = error_count;
        for (int i = 0; i < NUM_KEYS; i++) begin
            loaded[i] = key_t'($random(seed));
        end
        load_all();
        sort_expected();
        pulse_start();
        // Second start and loads, all while the sort runs
        pulse_start();
        fork
            wait_done();
            load_until_done();
        join
        read_back();
        finish_test("busy_inputs", errs);
    endtask

    task automatic test_resort();
        int errs;
        errs = error_count;
        pulse_start();
        wait_done();
        read_back();
        finish_test("resort", errs);
    endtask

    initial begin
        seed        = 17231;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        arst_n      = 1'b0;
        load        = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        start       = 1'b0;
        read_addr   = '0;

        repeat (2) @(posedge clock);
        arst_n <= 1'b1;

        test_reset_state();
        test_descending();
        test_ascending();
        for (int n = 0; n < 10; n++) begin
            test_random(n);
        end
        test_busy_inputs();
        test_resort();

        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
